/* rtl/icachePkg.sv */
package icachePkg;

  // address split for 64 sets of 32-byte lines
  localparam int AddrWidth    = 32;
  localparam int DataWidth    = 64;
  localparam int LineWidth    = 256;
  localparam int HalfWidth    = 128;
  localparam int TagWidth     = 21;
  localparam int IndexWidth   = 6;
  localparam int OffsetWidth  = 5;
  localparam int BeatsPerLine = 4;

  // offset bits 4:3 pick the word in the line
  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexWidth-1:0]  index;
    logic [OffsetWidth-1:0] offset;
  } cacheAddrFields_t;

  // one address word, raw or split
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    cacheAddrFields_t     fields;
  } cacheAddr_u;

  typedef struct packed {
    cacheAddr_u addr;
  } fetchReq_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
  } fetchResp_t;

  // len is beats minus one
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } memAr_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 last;
  } memR_t;

endpackage

/* rtl/dataSram.sv */
`timescale 1ns/1ps

module dataSram #(
  parameter int Depth = 64,
  parameter int Width = 128
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [Width-1:0]         wdata_i,
  output logic [Width-1:0]         rdata_o
);

  logic [Width-1:0] mem [Depth];
  logic [Width-1:0] rdataQ;

  // single port, write or read per cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        // read data held until the next read
        rdataQ <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdataQ;

endmodule

/* rtl/tagValidArray.sv */
`timescale 1ns/1ps

module tagValidArray import icachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       lookupEn_i,
  input  cacheAddr_u lookupAddr_i,
  input  logic       fillEn_i,
  input  logic       fillWay_i,
  input  cacheAddr_u fillAddr_i,
  output logic [1:0] wayHit_o,
  output logic [1:0] wayValid_o
);

  localparam int Sets = 2 ** IndexWidth;

  logic [TagWidth-1:0]      tagMem [2][Sets];
  logic [1:0][Sets-1:0]     validQ;
  logic [1:0][TagWidth-1:0] tagRdQ;
  logic [TagWidth-1:0]      reqTagQ;
  logic [1:0]               validRdQ;

  // valid bits, all sets cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ   <= '0;
      validRdQ <= '0;
    end else begin
      if (fillEn_i) begin
        validQ[fillWay_i][fillAddr_i.fields.index] <= 1'b1;
      end
      // snapshot of the looked-up set
      if (lookupEn_i) begin
        validRdQ[0] <= validQ[0][lookupAddr_i.fields.index];
        validRdQ[1] <= validQ[1][lookupAddr_i.fields.index];
      end
    end
  end

  // tag store plus registered read
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[fillWay_i][fillAddr_i.fields.index] <= fillAddr_i.fields.tag;
    end
    if (lookupEn_i) begin
      tagRdQ[0] <= tagMem[0][lookupAddr_i.fields.index];
      tagRdQ[1] <= tagMem[1][lookupAddr_i.fields.index];
      reqTagQ   <= lookupAddr_i.fields.tag;
    end
  end

  // per-way compare on registered values
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit_o[w] = validRdQ[w] && (tagRdQ[w] == reqTagQ);
    end
  end
  assign wayValid_o = validRdQ;

  // controller must not fill the set it is looking up
  assert property (@(posedge clk) disable iff (!rst_n)
    fillEn_i && lookupEn_i |-> fillAddr_i.fields.index != lookupAddr_i.fields.index);

endmodule

/* rtl/refillBuffer.sv */
`timescale 1ns/1ps

module refillBuffer import icachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  cacheAddr_u           lineAddr_i,
  output logic                 arValid_o,
  input  logic                 arReady_i,
  output memAr_t               ar_o,
  input  logic                 rValid_i,
  output logic                 rReady_o,
  input  memR_t                r_i,
  output logic                 lineDone_o,
  output logic [LineWidth-1:0] line_o
);

  localparam int PtrWidth = $clog2(BeatsPerLine);

  logic                 arValidQ;
  logic                 rReadyQ;
  logic                 lineDoneQ;
  logic [PtrWidth-1:0]  beatPtrQ;
  cacheAddr_u           arAddrQ;
  logic [LineWidth-1:0] lineQ;
  logic                 arFire;
  logic                 beatFire;

  assign arFire   = arValid_o && arReady_i;
  assign beatFire = rValid_i && rReady_o;

  // channel control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arValidQ  <= 1'b0;
      rReadyQ   <= 1'b0;
      lineDoneQ <= 1'b0;
      beatPtrQ  <= '0;
    end else begin
      lineDoneQ <= beatFire && r_i.last;
      if (start_i) begin
        arValidQ <= 1'b1;
        rReadyQ  <= 1'b1;
        beatPtrQ <= '0;
      end else begin
        if (arFire) begin
          arValidQ <= 1'b0;
        end
        if (beatFire) begin
          beatPtrQ <= beatPtrQ + 1'b1;
          // ready drops once the last beat is in
          if (r_i.last) begin
            rReadyQ <= 1'b0;
          end
        end
      end
    end
  end

  // line address with offset cleared, beats packed low first
  always_ff @(posedge clk) begin
    if (start_i) begin
      arAddrQ.raw <= {lineAddr_i.fields.tag, lineAddr_i.fields.index, OffsetWidth'(0)};
    end
    if (beatFire) begin
      lineQ[beatPtrQ*DataWidth +: DataWidth] <= r_i.data;
    end
  end

  assign arValid_o  = arValidQ;
  assign ar_o.addr  = arAddrQ.raw;
  assign ar_o.len   = 8'(BeatsPerLine - 1);
  assign rReady_o   = rReadyQ;
  assign lineDone_o = lineDoneQ;
  assign line_o     = lineQ;

  // memory must flag last on the fourth beat exactly
  assert property (@(posedge clk) disable iff (!rst_n)
    beatFire |-> r_i.last == (beatPtrQ == PtrWidth'(BeatsPerLine - 1)));

endmodule

/* rtl/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl import icachePkg::*; #(
  parameter logic [15:0] LfsrSeed = 16'hace1
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      reqValid_i,
  output logic                      reqReady_o,
  input  fetchReq_t                 req_i,
  output logic                      respValid_o,
  input  logic                      respReady_i,
  output fetchResp_t                resp_o,
  output logic                      lookupEn_o,
  output cacheAddr_u                lookupAddr_o,
  input  logic [1:0]                wayHit_i,
  input  logic [1:0]                wayValid_i,
  output logic                      fillEn_o,
  output logic                      fillWay_o,
  output cacheAddr_u                fillAddr_o,
  output logic                      refillStart_o,
  input  logic                      refillDone_i,
  input  logic [LineWidth-1:0]      refillLine_i,
  output logic [3:0]                sramEn_o,
  output logic [3:0]                sramWe_o,
  output logic [IndexWidth-1:0]     sramAddr_o,
  output logic [LineWidth-1:0]      sramWdata_o,
  input  logic [1:0][LineWidth-1:0] sramRdata_i
);

  typedef enum logic [2:0] {
    Idle,
    Compare,
    MissWait,
    Fill,
    Replay
  } ctrlState_e;

  ctrlState_e           stateQ;
  ctrlState_e           stateD;
  cacheAddr_u           reqAddrQ;
  logic                 reqFire;
  logic                 anyHit;
  logic                 victimD;
  logic                 victimQ;
  logic [15:0]          lfsrQ;
  logic [3:0]           fillMask;
  logic [LineWidth-1:0] hitLine;

  assign anyHit = |wayHit_i;

  // new request only when idle or a hit is leaving this cycle
  always_comb begin
    unique case (stateQ)
      Idle:    reqReady_o = 1'b1;
      Compare: reqReady_o = anyHit && respReady_i;
      default: reqReady_o = 1'b0;
    endcase
  end
  assign reqFire = reqValid_i && reqReady_o;

  always_comb begin
    stateD = stateQ;
    unique case (stateQ)
      Idle: begin
        if (reqFire) begin
          stateD = Compare;
        end
      end
      Compare: begin
        if (!anyHit) begin
          stateD = MissWait;
        end else if (respReady_i) begin
          // stay here when streaming hits
          stateD = reqFire ? Compare : Idle;
        end
      end
      MissWait: begin
        if (refillDone_i) begin
          stateD = Fill;
        end
      end
      Fill:    stateD = Replay;
      Replay:  stateD = Compare;
      default: stateD = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
      lfsrQ  <= LfsrSeed;
    end else begin
      stateQ <= stateD;
      // free-running, taps 16 14 13 11
      lfsrQ  <= {lfsrQ[14:0], lfsrQ[15] ^ lfsrQ[13] ^ lfsrQ[12] ^ lfsrQ[10]};
    end
  end

  // victim: lowest invalid way, else random
  always_comb begin
    if (!wayValid_i[0]) begin
      victimD = 1'b0;
    end else if (!wayValid_i[1]) begin
      victimD = 1'b1;
    end else begin
      victimD = lfsrQ[0];
    end
  end

  // request address and victim held for the whole miss
  always_ff @(posedge clk) begin
    if (reqFire) begin
      reqAddrQ <= req_i.addr;
    end
    if (refillStart_o) begin
      victimQ <= victimD;
    end
  end

  // lookup from the request port, or replay of the latched miss
  assign lookupEn_o   = reqFire || (stateQ == Replay);
  assign lookupAddr_o = (stateQ == Replay) ? reqAddrQ : req_i.addr;

  assign refillStart_o = (stateQ == Compare) && !anyHit;
  assign fillEn_o      = (stateQ == Fill);
  assign fillWay_o     = victimQ;
  assign fillAddr_o    = reqAddrQ;

  // sram order: way0 lo, way0 hi, way1 lo, way1 hi
  assign fillMask    = victimQ ? 4'b1100 : 4'b0011;
  assign sramWe_o    = fillEn_o ? fillMask : 4'b0000;
  assign sramWdata_o = refillLine_i;

  always_comb begin
    if (fillEn_o) begin
      sramEn_o   = fillMask;
      sramAddr_o = reqAddrQ.fields.index;
    end else begin
      sramEn_o   = lookupEn_o ? 4'b1111 : 4'b0000;
      sramAddr_o = lookupAddr_o.fields.index;
    end
  end

  // word comes from the sram read register of the hitting way
  assign hitLine     = wayHit_i[1] ? sramRdata_i[1] : sramRdata_i[0];
  assign resp_o.data = hitLine[reqAddrQ.fields.offset[OffsetWidth-1 -: 2]*DataWidth +: DataWidth];
  assign respValid_o = (stateQ == Compare) && anyHit;

  // a tag lives in one way only
  assert property (@(posedge clk) disable iff (!rst_n)
    !(&wayHit_i));

  // stalled response must not move
  assert property (@(posedge clk) disable iff (!rst_n)
    respValid_o && !respReady_i |=> respValid_o && $stable(resp_o));

endmodule

/* rtl/icacheTop.sv */
`timescale 1ns/1ps

module icacheTop import icachePkg::*; #(
  parameter logic [15:0] LfsrSeed = 16'hace1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       reqValid_i,
  output logic       reqReady_o,
  input  fetchReq_t  req_i,
  output logic       respValid_o,
  input  logic       respReady_i,
  output fetchResp_t resp_o,
  output logic       arValid_o,
  input  logic       arReady_i,
  output memAr_t     ar_o,
  input  logic       rValid_i,
  output logic       rReady_o,
  input  memR_t      r_i
);

  logic                      lookupEn;
  cacheAddr_u                lookupAddr;
  logic [1:0]                wayHit;
  logic [1:0]                wayValid;
  logic                      fillEn;
  logic                      fillWay;
  cacheAddr_u                fillAddr;
  logic                      refillStart;
  logic                      refillDone;
  logic [LineWidth-1:0]      refillLine;
  logic [3:0]                sramEn;
  logic [3:0]                sramWe;
  logic [IndexWidth-1:0]     sramAddr;
  logic [LineWidth-1:0]      sramWdata;
  wire  [1:0][LineWidth-1:0] sramRdata;

  cacheCtrl #(
    .LfsrSeed(LfsrSeed)
  ) cacheCtrl_i (
    .clk, .rst_n,
    .reqValid_i, .reqReady_o, .req_i,
    .respValid_o, .respReady_i, .resp_o,
    .lookupEn_o(lookupEn), .lookupAddr_o(lookupAddr),
    .wayHit_i(wayHit), .wayValid_i(wayValid),
    .fillEn_o(fillEn), .fillWay_o(fillWay), .fillAddr_o(fillAddr),
    .refillStart_o(refillStart), .refillDone_i(refillDone), .refillLine_i(refillLine),
    .sramEn_o(sramEn), .sramWe_o(sramWe), .sramAddr_o(sramAddr),
    .sramWdata_o(sramWdata), .sramRdata_i(sramRdata)
  );

  tagValidArray tagValidArray_i (
    .clk, .rst_n,
    .lookupEn_i(lookupEn), .lookupAddr_i(lookupAddr),
    .fillEn_i(fillEn), .fillWay_i(fillWay), .fillAddr_i(fillAddr),
    .wayHit_o(wayHit), .wayValid_o(wayValid)
  );

  refillBuffer refillBuffer_i (
    .clk, .rst_n,
    .start_i(refillStart), .lineAddr_i(fillAddr),
    .arValid_o, .arReady_i, .ar_o,
    .rValid_i, .rReady_o, .r_i,
    .lineDone_o(refillDone), .line_o(refillLine)
  );

  // each way split into low and high 128-bit halves
  dataSram #(.Depth(2 ** IndexWidth), .Width(HalfWidth)) sramWay0Lo (
    .clk, .en_i(sramEn[0]), .we_i(sramWe[0]), .addr_i(sramAddr),
    .wdata_i(sramWdata[HalfWidth-1:0]), .rdata_o(sramRdata[0][HalfWidth-1:0])
  );
  dataSram #(.Depth(2 ** IndexWidth), .Width(HalfWidth)) sramWay0Hi (
    .clk, .en_i(sramEn[1]), .we_i(sramWe[1]), .addr_i(sramAddr),
    .wdata_i(sramWdata[LineWidth-1:HalfWidth]), .rdata_o(sramRdata[0][LineWidth-1:HalfWidth])
  );
  dataSram #(.Depth(2 ** IndexWidth), .Width(HalfWidth)) sramWay1Lo (
    .clk, .en_i(sramEn[2]), .we_i(sramWe[2]), .addr_i(sramAddr),
    .wdata_i(sramWdata[HalfWidth-1:0]), .rdata_o(sramRdata[1][HalfWidth-1:0])
  );
  dataSram #(.Depth(2 ** IndexWidth), .Width(HalfWidth)) sramWay1Hi (
    .clk, .en_i(sramEn[3]), .we_i(sramWe[3]), .addr_i(sramAddr),
    .wdata_i(sramWdata[LineWidth-1:HalfWidth]), .rdata_o(sramRdata[1][LineWidth-1:HalfWidth])
  );

endmodule

/* dv/memReadModel.sv */
`timescale 1ns/1ps

module memReadModel import icachePkg::*; #(
  parameter int MaxDelay = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   arValid_i,
  output logic   arReady_o,
  input  memAr_t ar_i,
  output logic   rValid_o,
  input  logic   rReady_i,
  output memR_t  r_o
);

  // each beat carries its own byte address, then that address inverted
  function automatic logic [DataWidth-1:0] beatData(input logic [AddrWidth-1:0] byteAddr);
    return {byteAddr, ~byteAddr};
  endfunction

  // wait whole cycles, ending 1 ns past the edge
  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    logic [AddrWidth-1:0] lineAddr;
    int                   beats;
    bit                   taken;
    arReady_o = 1'b0;
    rValid_o  = 1'b0;
    r_o       = '0;
    forever begin
      @(negedge clk);
      if (rst_n && arValid_i) begin
        lineAddr = ar_i.addr;
        beats    = int'(ar_i.len) + 1;
        @(posedge clk);
        #1;
        // random address latency, cache holds the request meanwhile
        idleCycles($urandom % MaxDelay);
        arReady_o = 1'b1;
        idleCycles(1);
        arReady_o = 1'b0;
        for (int b = 0; b < beats; b++) begin
          // gap before each beat
          idleCycles($urandom % MaxDelay);
          rValid_o = 1'b1;
          r_o.data = beatData(lineAddr + AddrWidth'(b * 8));
          r_o.last = (b == beats - 1);
          do begin
            @(negedge clk);
            taken = rReady_i;
            @(posedge clk);
            #1;
          end while (!taken);
          rValid_o = 1'b0;
        end
      end
    end
  end

endmodule

/* dv/icacheTb.sv */
`timescale 1ns/1ps

module icacheTb import icachePkg::*; ();

  localparam int KindAny  = 0;
  localparam int KindHit  = 1;
  localparam int KindMiss = 2;
  // about 215 fetches, none close to 90 cycles even with stalls
  localparam int TimeoutCycles = 20000;

  logic       clk;
  logic       rst_n;
  logic       reqValid;
  logic       reqReady;
  fetchReq_t  req;
  logic       respValid;
  logic       respReady;
  fetchResp_t resp;
  logic       arValid;
  logic       arReady;
  memAr_t     ar;
  logic       rValid;
  logic       rReady;
  memR_t      r;

  // scoreboard, one fetch in flight
  int                   reqKind;
  int                   curKindQ;
  int                   arCountQ;
  int                   cycleCount = 0;
  logic                 outstandingQ;
  logic [AddrWidth-1:0] curAddrQ;
  logic [DataWidth-1:0] expDataQ;
  logic                 stallQ;
  logic [DataWidth-1:0] prevRespQ;

  icacheTop #(.LfsrSeed(16'h5a3c)) icacheTop_i (
    .clk, .rst_n,
    .reqValid_i(reqValid), .reqReady_o(reqReady), .req_i(req),
    .respValid_o(respValid), .respReady_i(respReady), .resp_o(resp),
    .arValid_o(arValid), .arReady_i(arReady), .ar_o(ar),
    .rValid_i(rValid), .rReady_o(rReady), .r_i(r)
  );

  memReadModel memReadModel_i (
    .clk, .rst_n,
    .arValid_i(arValid), .arReady_o(arReady), .ar_i(ar),
    .rValid_o(rValid), .rReady_i(rReady), .r_o(r)
  );

  // word at the fetch address rounded down to 8 bytes
  function automatic logic [DataWidth-1:0] expectedWord(input logic [AddrWidth-1:0] addr);
    logic [AddrWidth-1:0] wordAddr;
    wordAddr = {addr[AddrWidth-1:3], 3'b000};
    return {wordAddr, ~wordAddr};
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      failRun("timeout: fetch sequences did not finish within the cycle limit");
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstandingQ <= 1'b0;
      arCountQ     <= 0;
      stallQ       <= 1'b0;
    end else begin
      stallQ    <= respValid && !respReady;
      prevRespQ <= resp.data;
      if (respValid && respReady) begin
        outstandingQ <= 1'b0;
      end
      if (reqValid && reqReady) begin
        outstandingQ <= 1'b1;
        curAddrQ     <= req.addr.raw;
        curKindQ     <= reqKind;
        expDataQ     <= expectedWord(req.addr.raw);
        arCountQ     <= 0;
      end else if (arValid && arReady) begin
        arCountQ <= arCountQ + 1;
      end
    end
  end

  assert property (@(posedge clk) !rst_n |-> !respValid && !arValid && !rReady && reqReady)
    else failRun("outputs not at their reset values while reset is held");
  assert property (@(posedge clk) disable iff (!rst_n) respValid |-> outstandingQ)
    else failRun("response presented with no fetch outstanding");
  assert property (@(posedge clk) disable iff (!rst_n) respValid |-> resp.data == expDataQ)
    else failRun($sformatf("MISMATCH time %0t resp_o.data got %h expected %h",
                           $time, $sampled(resp.data), $sampled(expDataQ)));
  // line request is the aligned fetch address, four beats
  assert property (@(posedge clk) disable iff (!rst_n)
    arValid && arReady |-> ar.addr == {curAddrQ[AddrWidth-1:OffsetWidth], OffsetWidth'(0)})
    else failRun($sformatf("MISMATCH time %0t ar_o.addr got %h expected %h", $time,
                           $sampled(ar.addr), {$sampled(curAddrQ[AddrWidth-1:OffsetWidth]), 5'b0}));
  assert property (@(posedge clk) disable iff (!rst_n) arValid && arReady |-> ar.len == 8'd3)
    else failRun($sformatf("MISMATCH time %0t ar_o.len got %0d expected 3",
                           $time, $sampled(ar.len)));
  assert property (@(posedge clk) disable iff (!rst_n) arValid && arReady |-> arCountQ == 0)
    else failRun("a second line request was issued for one fetch");
  assert property (@(posedge clk) disable iff (!rst_n) arValid |-> curKindQ != KindHit)
    else failRun("line request issued for a fetch that should hit");
  assert property (@(posedge clk) disable iff (!rst_n)
    respValid && respReady && curKindQ == KindMiss |-> arCountQ == 1)
    else failRun("expected miss finished without a line request");
  assert property (@(posedge clk) disable iff (!rst_n)
    reqValid && reqReady && reqKind == KindHit |=> respValid)
    else failRun("hit was not answered one cycle after acceptance");
  // stalled response holds, no new fetch taken
  assert property (@(posedge clk) disable iff (!rst_n) stallQ |-> respValid)
    else failRun("response valid dropped while the response was stalled");
  assert property (@(posedge clk) disable iff (!rst_n) stallQ |-> resp.data == prevRespQ)
    else failRun($sformatf("MISMATCH time %0t resp_o.data got %h expected %h",
                           $time, $sampled(resp.data), $sampled(prevRespQ)));
  assert property (@(posedge clk) disable iff (!rst_n) respValid && !respReady |-> !reqReady)
    else failRun("request ready high while the response was stalled");

  task automatic fetch(input logic [AddrWidth-1:0] addr, input int kind, input bit stall,
                       output bit missed);
    bit fired;
    bit done;
    reqValid       = 1'b1;
    req.addr.raw   = addr;
    reqKind        = kind;
    respReady      = 1'b1;
    do begin
      @(negedge clk);
      fired = reqReady;
      @(posedge clk);
      #1;
    end while (!fired);
    reqValid = 1'b0;
    do begin
      // random stalls on one cycle in three
      respReady = stall ? ($urandom % 3 != 0) : 1'b1;
      @(negedge clk);
      done = respValid && respReady;
      @(posedge clk);
      #1;
    end while (!done);
    missed = (arCountQ != 0);
  endtask

  // cold miss, then each word of the line at an unaligned byte
  task automatic firstFills();
    bit missed;
    fetch(32'h0000_1058, KindMiss, 1'b0, missed);
    for (int w = 0; w < BeatsPerLine; w++) begin
      fetch(32'h0000_1040 + AddrWidth'(w * 9), KindHit, 1'b0, missed);
    end
  endtask

  task automatic twoWaySets();
    logic [AddrWidth-1:0] lineA;
    logic [AddrWidth-1:0] lineB;
    logic [AddrWidth-1:0] lineC;
    bit                   missed;
    for (int s = 10; s < 14; s++) begin
      lineA = {21'h100, 6'(s), 5'h00};
      lineB = {21'h200, 6'(s), 5'h08};
      lineC = {21'h300, 6'(s), 5'h10};
      fetch(lineA, KindMiss, 1'b0, missed);
      fetch(lineB, KindMiss, 1'b0, missed);
      fetch(lineA, KindHit, 1'b0, missed);
      fetch(lineB, KindHit, 1'b0, missed);
      fetch(lineC, KindMiss, 1'b0, missed);
      // third tag pushed out one of the two; if A stayed, B was the victim
      fetch(lineA, KindAny, 1'b0, missed);
      fetch(lineB, missed ? KindAny : KindMiss, 1'b0, missed);
    end
  endtask

  task automatic randomTraffic(input int count, input bit stall);
    logic [AddrWidth-1:0] addr;
    bit                   missed;
    for (int i = 0; i < count; i++) begin
      // three tags over sixteen sets, hits and evictions both common
      addr = {21'(8 + $urandom % 3), 6'($urandom % 16), 5'($urandom % 32)};
      fetch(addr, KindAny, stall, missed);
    end
  endtask

  initial begin
    void'($urandom(32'h0d85_dd33));
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    req       = '0;
    respReady = 1'b0;
    reqKind   = KindAny;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    firstFills();
    twoWaySets();
    randomTraffic(60, 1'b0);
    randomTraffic(60, 1'b1);
    randomTraffic(60, 1'b1);
    @(posedge clk);
    #1;
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* icacheSub.f */
rtl/icachePkg.sv
rtl/dataSram.sv
rtl/tagValidArray.sv
rtl/refillBuffer.sv
rtl/cacheCtrl.sv
rtl/icacheTop.sv
dv/memReadModel.sv
dv/icacheTb.sv
